/* source/ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [6:0] square_idx_t;
    typedef logic [7:0] color_t;
    typedef logic [3:0] offset_t;

    typedef enum logic [1:0] {sq_empty, sq_miss, sq_hit, sq_ship} square_state_e;
    typedef enum logic [1:0] {ship_len2, ship_len3, ship_len4, ship_len5} ship_kind_e;
    typedef enum logic [1:0] {reg_background, reg_border, reg_square} region_e;

    // bit order kept from the game logic encoding
    typedef struct packed {
        square_state_e state;
        ship_kind_e    kind;
        logic [2:0]    section;
        logic          vert;
        logic          sel;
        logic          ai;
    } square_info_t;

    typedef struct packed {
        logic         board;
        square_idx_t  index;
        square_info_t info;
    } square_update_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   active;
        logic   hsync;
        logic   vsync;
    } pixel_pos_t;

    typedef struct packed {
        pixel_pos_t  pos;
        region_e     region;
        logic        board;
        square_idx_t index;
        offset_t     off_x;
        offset_t     off_y;
    } located_t;

    typedef struct packed {
        located_t loc;
        color_t   color;
        logic     sel;
        logic     ai;
    } fetched_t;

    // 640x480 at 60 Hz, syncs active low
    localparam coord_t H_ACTIVE     = 10'd640;
    localparam coord_t H_SYNC_START = 10'd656;
    localparam coord_t H_SYNC_END   = 10'd752;
    localparam coord_t H_TOTAL      = 10'd800;
    localparam coord_t V_ACTIVE     = 10'd480;
    localparam coord_t V_SYNC_START = 10'd490;
    localparam coord_t V_SYNC_END   = 10'd492;
    localparam coord_t V_TOTAL      = 10'd525;

    localparam int SQUARE_SIZE  = 16;
    localparam int GRID_SQUARES = 10;
    localparam int GRID_PIXELS  = SQUARE_SIZE * GRID_SQUARES;
    localparam int NUM_SQUARES  = GRID_SQUARES * GRID_SQUARES;

    // 3-3-2 colors, rrr_ggg_bb
    localparam color_t WATER_COLOR  = 8'b000_010_10;
    localparam color_t SAND_COLOR   = 8'b110_101_01;
    localparam color_t BORDER_COLOR = 8'b010_010_01;
    localparam color_t GRID_COLOR   = 8'b000_001_01;
    localparam color_t MISS_COLOR   = 8'b111_111_11;
    localparam color_t HIT_COLOR    = 8'b111_000_00;
    localparam color_t BOW_COLOR    = 8'b111_110_00;
    localparam color_t AI_COLOR     = 8'b000_111_00;
    localparam color_t SHIP_COLOR [4] = '{8'b100_100_10, 8'b011_011_01,
                                          8'b101_101_10, 8'b010_010_10};

    // pipeline contents while idle or in reset
    localparam pixel_pos_t POS_IDLE = '{x: '0, y: '0, active: 1'b0, hsync: 1'b1, vsync: 1'b1};
    localparam located_t LOC_IDLE = '{pos: POS_IDLE, region: reg_background, board: 1'b0,
                                      index: '0, off_x: '0, off_y: '0};

endpackage

`default_nettype wire

/* source/vga_timing.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_timing (
    input  wire                  vga_clk,
    input  wire                  rst_n,
    output ppu_pkg::pixel_pos_t  pos,
    output logic                 in_blank
);

    ppu_pkg::coord_t x;
    ppu_pkg::coord_t y;
    logic            h_active;
    logic            v_active;
    logic            h_pulse;
    logic            v_pulse;

    // x runs over the full line, y steps at the end of each line
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else if (x == ppu_pkg::H_TOTAL - 10'd1) begin
            x <= '0;
            if (y == ppu_pkg::V_TOTAL - 10'd1) begin
                y <= '0;
            end else begin
                y <= y + 10'd1;
            end
        end else begin
            x <= x + 10'd1;
        end
    end

    always_comb begin
        h_active = x < ppu_pkg::H_ACTIVE;
        v_active = y < ppu_pkg::V_ACTIVE;
        h_pulse  = (x >= ppu_pkg::H_SYNC_START) && (x < ppu_pkg::H_SYNC_END);
        v_pulse  = (y >= ppu_pkg::V_SYNC_START) && (y < ppu_pkg::V_SYNC_END);
    end

    always_comb begin
        pos.x      = x;
        pos.y      = y;
        pos.active = h_active && v_active;
        // sync pulses are active low
        pos.hsync  = !h_pulse;
        pos.vsync  = !v_pulse;
    end

    // store read port is free whenever the beam is off screen
    assign in_blank = !(h_active && v_active);

    a_x_in_line: assert property (
        @(posedge vga_clk) disable iff (!rst_n)
        x < ppu_pkg::H_TOTAL
    ) else $error("horizontal counter ran past the end of the line");

endmodule

`default_nettype wire

/* source/square_store.sv */
`timescale 1ns/1ns
`default_nettype none

module square_store (
    input  wire                           vga_clk,
    input  wire                           rst_n,
    input  wire ppu_pkg::square_update_t  update,
    input  wire                           update_valid,
    output logic                          update_ready,
    input  wire                           in_blank,
    input  wire                           rd_board,
    input  wire ppu_pkg::square_idx_t     rd_index,
    output ppu_pkg::square_info_t         rd_info
);

    // [board][square]
    ppu_pkg::square_info_t mem [2][ppu_pkg::NUM_SQUARES];
    logic                  wr_en;

    // single port, so game updates wait for blanking
    assign update_ready = in_blank;
    assign wr_en        = update_valid && update_ready;

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            mem <= '{default: '0};
        end else if (wr_en) begin
            mem[update.board][update.index] <= update.info;
        end
    end

    // one cycle read for the fetch stage
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_info <= '0;
        end else begin
            rd_info <= mem[rd_board][rd_index];
        end
    end

    a_update_index: assert property (
        @(posedge vga_clk) disable iff (!rst_n)
        wr_en |-> (update.index < ppu_pkg::square_idx_t'(ppu_pkg::NUM_SQUARES))
    ) else $error("square update index %0d out of range", update.index);

    // update held steady by the sender until taken
    a_update_stable: assert property (
        @(posedge vga_clk) disable iff (!rst_n)
        (update_valid && !update_ready) |=> (update_valid && $stable(update))
    ) else $error("square update dropped or changed before transfer");

endmodule

`default_nettype wire

/* source/square_locate.sv */
`timescale 1ns/1ns
`default_nettype none

module square_locate #(
    parameter int BOARD_X      = 240,
    parameter int BOARD0_Y     = 40,
    parameter int BOARD_GAP    = 40,
    parameter int BORDER_WIDTH = 4
) (
    input  wire                        vga_clk,
    input  wire                        rst_n,
    input  wire ppu_pkg::pixel_pos_t   pos,
    output ppu_pkg::located_t          located,
    output logic                       rd_board,
    output ppu_pkg::square_idx_t       rd_index
);

    // outer size of one board, grid plus border on both sides
    localparam int BOARD_EXT = ppu_pkg::GRID_PIXELS + 2 * BORDER_WIDTH;
    localparam int BOARD1_Y  = BOARD0_Y + BOARD_EXT + BOARD_GAP;

    localparam ppu_pkg::coord_t X_LO    = ppu_pkg::coord_t'(BOARD_X);
    localparam ppu_pkg::coord_t X_HI    = ppu_pkg::coord_t'(BOARD_X + BOARD_EXT);
    localparam ppu_pkg::coord_t Y0_LO   = ppu_pkg::coord_t'(BOARD0_Y);
    localparam ppu_pkg::coord_t Y0_HI   = ppu_pkg::coord_t'(BOARD0_Y + BOARD_EXT);
    localparam ppu_pkg::coord_t Y1_LO   = ppu_pkg::coord_t'(BOARD1_Y);
    localparam ppu_pkg::coord_t Y1_HI   = ppu_pkg::coord_t'(BOARD1_Y + BOARD_EXT);
    localparam ppu_pkg::coord_t GRID_LO = ppu_pkg::coord_t'(BORDER_WIDTH);
    localparam ppu_pkg::coord_t GRID_HI = ppu_pkg::coord_t'(BORDER_WIDTH + ppu_pkg::GRID_PIXELS);

    logic                 in_x;
    logic                 in_y0;
    logic                 in_y1;
    logic                 in_board;
    logic                 in_grid;
    ppu_pkg::coord_t      rel_x;
    ppu_pkg::coord_t      rel_y;
    ppu_pkg::coord_t      grid_x;
    ppu_pkg::coord_t      grid_y;
    logic [3:0]           col;
    logic [3:0]           row;
    ppu_pkg::square_idx_t index;
    ppu_pkg::region_e     region;

    always_comb begin
        in_x     = (pos.x >= X_LO) && (pos.x < X_HI);
        in_y0    = (pos.y >= Y0_LO) && (pos.y < Y0_HI);
        in_y1    = (pos.y >= Y1_LO) && (pos.y < Y1_HI);
        in_board = in_x && (in_y0 || in_y1);

        // offsets relative to the board's outer corner
        rel_x = pos.x - X_LO;
        rel_y = pos.y - (in_y1 ? Y1_LO : Y0_LO);

        in_grid = in_board && (rel_x >= GRID_LO) && (rel_x < GRID_HI)
                  && (rel_y >= GRID_LO) && (rel_y < GRID_HI);

        grid_x = rel_x - GRID_LO;
        grid_y = rel_y - GRID_LO;
        col    = 4'(grid_x / ppu_pkg::SQUARE_SIZE);
        row    = 4'(grid_y / ppu_pkg::SQUARE_SIZE);
        index  = ppu_pkg::square_idx_t'(row) * ppu_pkg::square_idx_t'(ppu_pkg::GRID_SQUARES)
                 + ppu_pkg::square_idx_t'(col);

        if (in_grid) begin
            region = ppu_pkg::reg_square;
        end else if (in_board) begin
            region = ppu_pkg::reg_border;
        end else begin
            region = ppu_pkg::reg_background;
        end
    end

    // read request goes out now, data comes back with the registered stage
    assign rd_board = in_y1;
    assign rd_index = in_grid ? index : '0;

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            located <= ppu_pkg::LOC_IDLE;
        end else begin
            located.pos    <= pos;
            located.region <= region;
            located.board  <= rd_board;
            located.index  <= rd_index;
            located.off_x  <= ppu_pkg::offset_t'(grid_x % ppu_pkg::SQUARE_SIZE);
            located.off_y  <= ppu_pkg::offset_t'(grid_y % ppu_pkg::SQUARE_SIZE);
        end
    end

endmodule

`default_nettype wire

/* source/sprite_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module sprite_fetch #(
    parameter int SHORE_Y = 440
) (
    input  wire                          vga_clk,
    input  wire                          rst_n,
    input  wire ppu_pkg::located_t       located,
    input  wire ppu_pkg::square_info_t   rd_info,
    output ppu_pkg::fetched_t            fetched
);

    // miss dot spans offsets 4 to 11, bow band is the first 4 pixels
    localparam ppu_pkg::offset_t MARK_LO   = 4'd4;
    localparam ppu_pkg::offset_t MARK_HI   = 4'd11;
    localparam ppu_pkg::offset_t BOW_DEPTH = 4'd4;

    ppu_pkg::offset_t off_x;
    ppu_pkg::offset_t off_y;
    ppu_pkg::offset_t axis_off;
    logic             miss_dot;
    logic             hit_cross;
    logic             in_square;
    ppu_pkg::color_t  ship_px;
    ppu_pkg::color_t  square_px;
    ppu_pkg::color_t  base;

    always_comb begin
        off_x    = located.off_x;
        off_y    = located.off_y;
        axis_off = rd_info.vert ? off_y : off_x;

        miss_dot  = (off_x >= MARK_LO) && (off_x <= MARK_HI)
                    && (off_y >= MARK_LO) && (off_y <= MARK_HI);
        // both diagonals, the second is off_x + off_y == 15
        hit_cross = (off_x == off_y) || (off_y == ~off_x);

        if ((rd_info.section == 3'd0) && (axis_off < BOW_DEPTH)) begin
            ship_px = ppu_pkg::BOW_COLOR;
        end else begin
            ship_px = ppu_pkg::SHIP_COLOR[rd_info.kind];
        end

        case (rd_info.state)
            ppu_pkg::sq_miss: begin
                square_px = miss_dot ? ppu_pkg::MISS_COLOR : ppu_pkg::WATER_COLOR;
            end
            ppu_pkg::sq_hit: begin
                square_px = hit_cross ? ppu_pkg::HIT_COLOR : ppu_pkg::WATER_COLOR;
            end
            ppu_pkg::sq_ship: begin
                // enemy fleet on board 0 stays hidden
                square_px = located.board ? ship_px : ppu_pkg::WATER_COLOR;
            end
            default: begin
                square_px = ppu_pkg::WATER_COLOR;
            end
        endcase

        in_square = located.region == ppu_pkg::reg_square;

        case (located.region)
            ppu_pkg::reg_square: base = square_px;
            ppu_pkg::reg_border: base = ppu_pkg::BORDER_COLOR;
            default: begin
                if (located.pos.y < ppu_pkg::coord_t'(SHORE_Y)) begin
                    base = ppu_pkg::WATER_COLOR;
                end else begin
                    base = ppu_pkg::SAND_COLOR;
                end
            end
        endcase
    end

    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            fetched <= '{loc: ppu_pkg::LOC_IDLE, color: '0, sel: 1'b0, ai: 1'b0};
        end else begin
            fetched.loc   <= located;
            fetched.color <= base;
            // flags only mean something inside a square
            fetched.sel   <= in_square && rd_info.sel;
            fetched.ai    <= in_square && rd_info.ai;
        end
    end

endmodule

`default_nettype wire

/* source/pixel_compose.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_compose (
    input  wire                      vga_clk,
    input  wire                      rst_n,
    input  wire ppu_pkg::fetched_t   fetched,
    output logic [7:0]               r,
    output logic [7:0]               g,
    output logic [7:0]               b,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     blank_n
);

    logic            on_grid;
    logic            active;
    ppu_pkg::color_t tinted;
    ppu_pkg::color_t final_px;

    always_comb begin
        // grid lines sit on the first row and column of every square
        on_grid = (fetched.loc.region == ppu_pkg::reg_square)
                  && ((fetched.loc.off_x == 4'd0) || (fetched.loc.off_y == 4'd0));
        active  = fetched.loc.pos.active;

        tinted = fetched.ai ? ppu_pkg::AI_COLOR : fetched.color;

        if (on_grid) begin
            final_px = ppu_pkg::GRID_COLOR;
        end else if (fetched.sel) begin
            // cursor
            final_px = ~tinted;
        end else begin
            final_px = tinted;
        end

        if (!active) begin
            final_px = '0;
        end
    end

    // 3-3-2 to 8-8-8, low bits zero
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            r       <= '0;
            g       <= '0;
            b       <= '0;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            blank_n <= 1'b0;
        end else begin
            r       <= {final_px[7:5], 5'b0};
            g       <= {final_px[4:2], 5'b0};
            b       <= {final_px[1:0], 6'b0};
            hsync   <= fetched.loc.pos.hsync;
            vsync   <= fetched.loc.pos.vsync;
            blank_n <= active;
        end
    end

endmodule

`default_nettype wire

/* source/ppu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ppu_top #(
    parameter int BOARD_X      = 240,
    parameter int BOARD0_Y     = 40,
    parameter int BOARD_GAP    = 40,
    parameter int BORDER_WIDTH = 4,
    parameter int SHORE_Y      = 440
) (
    input  wire                           vga_clk,
    input  wire                           rst_n,
    input  wire ppu_pkg::square_update_t  update,
    input  wire                           update_valid,
    output logic                          update_ready,
    output logic [7:0]                    r,
    output logic [7:0]                    g,
    output logic [7:0]                    b,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          blank_n
);

    ppu_pkg::pixel_pos_t   pos;
    ppu_pkg::located_t     located;
    ppu_pkg::fetched_t     fetched;
    ppu_pkg::square_info_t rd_info;
    ppu_pkg::square_idx_t  rd_index;
    logic                  rd_board;
    logic                  in_blank;

    vga_timing i_vga_timing (
        .vga_clk  (vga_clk),
        .rst_n    (rst_n),
        .pos      (pos),
        .in_blank (in_blank)
    );

    square_store i_square_store (
        .vga_clk      (vga_clk),
        .rst_n        (rst_n),
        .update       (update),
        .update_valid (update_valid),
        .update_ready (update_ready),
        .in_blank     (in_blank),
        .rd_board     (rd_board),
        .rd_index     (rd_index),
        .rd_info      (rd_info)
    );

    // stage 1
    square_locate #(
        .BOARD_X      (BOARD_X),
        .BOARD0_Y     (BOARD0_Y),
        .BOARD_GAP    (BOARD_GAP),
        .BORDER_WIDTH (BORDER_WIDTH)
    ) i_square_locate (
        .vga_clk  (vga_clk),
        .rst_n    (rst_n),
        .pos      (pos),
        .located  (located),
        .rd_board (rd_board),
        .rd_index (rd_index)
    );

    // stage 2
    sprite_fetch #(
        .SHORE_Y (SHORE_Y)
    ) i_sprite_fetch (
        .vga_clk (vga_clk),
        .rst_n   (rst_n),
        .located (located),
        .rd_info (rd_info),
        .fetched (fetched)
    );

    // stage 3
    pixel_compose i_pixel_compose (
        .vga_clk (vga_clk),
        .rst_n   (rst_n),
        .fetched (fetched),
        .r       (r),
        .g       (g),
        .b       (b),
        .hsync   (hsync),
        .vsync   (vsync),
        .blank_n (blank_n)
    );

endmodule

`default_nettype wire

/* tb/ppu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ppu_tb;

    localparam int BOARD_X      = 240;
    localparam int BOARD0_Y     = 40;
    localparam int BOARD_GAP    = 40;
    localparam int BORDER_WIDTH = 4;
    localparam int SHORE_Y      = 440;
    localparam int BOARD_EXT    = 168;
    localparam int BOARD1_Y     = BOARD0_Y + BOARD_EXT + BOARD_GAP;
    localparam int H_ACTIVE     = 640;
    localparam int V_ACTIVE     = 480;
    localparam int FRAME_LIMIT  = 2 * 800 * 525;
    localparam int UPDATE_LIMIT = 2000;
    localparam int PRINT_LIMIT  = 10;

    logic                    vga_clk = 1'b0;
    logic                    rst_n;
    ppu_pkg::square_update_t update;
    logic                    update_valid;
    logic                    update_ready;
    logic [7:0]              r;
    logic [7:0]              g;
    logic [7:0]              b;
    logic                    hsync;
    logic                    vsync;
    logic                    blank_n;

    // expected contents of the square store
    ppu_pkg::square_info_t ref_mem [2][100];
    logic [31:0]           lfsr;
    string                 test_name;
    int                    test_errors;
    int                    total_errors;
    int                    failed_tests;
    int                    test_count;
    int                    last_stall;
    logic                  hung;

    always #5 vga_clk = ~vga_clk;

    ppu_top #(
        .BOARD_X      (BOARD_X),
        .BOARD0_Y     (BOARD0_Y),
        .BOARD_GAP    (BOARD_GAP),
        .BORDER_WIDTH (BORDER_WIDTH),
        .SHORE_Y      (SHORE_Y)
    ) i_ppu_top (
        .vga_clk      (vga_clk),
        .rst_n        (rst_n),
        .update       (update),
        .update_valid (update_valid),
        .update_ready (update_ready),
        .r            (r),
        .g            (g),
        .b            (b),
        .hsync        (hsync),
        .vsync        (vsync),
        .blank_n      (blank_n)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic ppu_pkg::square_info_t make_info(input int state, input int kind,
                                                        input int section, input int vert,
                                                        input int sel, input int ai);
        ppu_pkg::square_info_t info;
        info.state   = ppu_pkg::square_state_e'(state[1:0]);
        info.kind    = ppu_pkg::ship_kind_e'(kind[1:0]);
        info.section = section[2:0];
        info.vert    = vert[0];
        info.sel     = sel[0];
        info.ai      = ai[0];
        return info;
    endfunction

    // reference pixel, 3-3-2, for a visible coordinate
    function automatic ppu_pkg::color_t expected_pixel(input int x, input int y);
        int                    bd;
        int                    top;
        int                    rx;
        int                    ry;
        int                    ox;
        int                    oy;
        int                    axis;
        ppu_pkg::square_info_t info;
        ppu_pkg::color_t       c;
        bd  = -1;
        top = 0;
        if (x >= BOARD_X && x < BOARD_X + BOARD_EXT) begin
            if (y >= BOARD0_Y && y < BOARD0_Y + BOARD_EXT) begin
                bd  = 0;
                top = BOARD0_Y;
            end else if (y >= BOARD1_Y && y < BOARD1_Y + BOARD_EXT) begin
                bd  = 1;
                top = BOARD1_Y;
            end
        end
        if (bd < 0) begin
            return (y < SHORE_Y) ? ppu_pkg::WATER_COLOR : ppu_pkg::SAND_COLOR;
        end
        rx = x - BOARD_X - BORDER_WIDTH;
        ry = y - top - BORDER_WIDTH;
        if (rx < 0 || ry < 0 || rx >= 160 || ry >= 160) begin
            return ppu_pkg::BORDER_COLOR;
        end
        ox   = rx % 16;
        oy   = ry % 16;
        info = ref_mem[bd][(ry / 16) * 10 + rx / 16];
        if (ox == 0 || oy == 0) begin
            return ppu_pkg::GRID_COLOR;
        end
        case (info.state)
            ppu_pkg::sq_miss: begin
                c = (ox >= 4 && ox <= 11 && oy >= 4 && oy <= 11) ?
                    ppu_pkg::MISS_COLOR : ppu_pkg::WATER_COLOR;
            end
            ppu_pkg::sq_hit: begin
                c = (ox == oy || ox + oy == 15) ? ppu_pkg::HIT_COLOR : ppu_pkg::WATER_COLOR;
            end
            ppu_pkg::sq_ship: begin
                axis = info.vert ? oy : ox;
                if (bd == 0) begin
                    c = ppu_pkg::WATER_COLOR;
                end else if (info.section == 3'd0 && axis < 4) begin
                    c = ppu_pkg::BOW_COLOR;
                end else begin
                    c = ppu_pkg::SHIP_COLOR[info.kind];
                end
            end
            default: c = ppu_pkg::WATER_COLOR;
        endcase
        if (info.ai) begin
            c = ppu_pkg::AI_COLOR;
        end
        return info.sel ? ~c : c;
    endfunction

    function automatic logic sync_level(input int which);
        return (which == 0) ? hsync : vsync;
    endfunction

    task automatic note_error();
        test_errors++;
    endtask

    task automatic compare_color(input int x, input int y, input ppu_pkg::color_t exp,
                                 input ppu_pkg::color_t act);
        if (exp !== act) begin
            note_error();
            if (test_errors <= PRINT_LIMIT) begin
                $display("error %s pixel (%0d,%0d): expected %02h, actual %02h",
                         test_name, x, y, exp, act);
            end
        end
    endtask

    task automatic compare_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            note_error();
            if (test_errors <= PRINT_LIMIT) begin
                $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
            end
        end
    endtask

    task automatic compare_count(input string what, input int exp, input int act);
        if (exp != act) begin
            note_error();
            if (test_errors <= PRINT_LIMIT) begin
                $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            end
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout in %s: %s never arrived", test_name, what);
        note_error();
        hung = 1'b1;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_count++;
    endtask

    task automatic end_test();
        total_errors += test_errors;
        if (test_errors > 0) begin
            failed_tests++;
        end
        $display("%-14s %s, %0d errors", test_name, (test_errors == 0) ? "passed" : "failed",
                 test_errors);
    endtask

    // offers one update and holds it until the store takes it
    task automatic send_update(input int bd, input int idx, input ppu_pkg::square_info_t info);
        int guard;
        guard      = 0;
        last_stall = 0;
        @(posedge vga_clk);
        update       <= '{board: bd[0], index: ppu_pkg::square_idx_t'(idx), info: info};
        update_valid <= 1'b1;
        @(negedge vga_clk);
        while (update_ready !== 1'b1 && guard < UPDATE_LIMIT) begin
            last_stall++;
            guard++;
            @(negedge vga_clk);
        end
        @(posedge vga_clk);
        update_valid <= 1'b0;
        if (guard >= UPDATE_LIMIT) begin
            report_timeout("update_ready");
        end else begin
            ref_mem[bd][idx] = info;
        end
    endtask

    task automatic measure_low_run(input int which, output int len);
        int guard;
        guard = 0;
        len   = 0;
        while (sync_level(which) !== 1'b1 && guard < FRAME_LIMIT) begin
            @(negedge vga_clk);
            guard++;
        end
        while (sync_level(which) !== 1'b0 && guard < FRAME_LIMIT) begin
            @(negedge vga_clk);
            guard++;
        end
        while (sync_level(which) === 1'b0 && guard < FRAME_LIMIT) begin
            len++;
            @(negedge vga_clk);
            guard++;
        end
        if (guard >= FRAME_LIMIT) begin
            report_timeout("sync pulse");
        end
    endtask

    // position comes from blank_n runs and vsync, not from the pipeline depth
    task automatic scan_frame();
        int              guard;
        int              line;
        int              px;
        logic            prev;
        ppu_pkg::color_t act;
        guard = 0;
        while (vsync !== 1'b0 && guard < FRAME_LIMIT) begin
            @(negedge vga_clk);
            guard++;
        end
        while (vsync !== 1'b1 && guard < FRAME_LIMIT) begin
            @(negedge vga_clk);
            guard++;
        end
        line = -1;
        px   = 0;
        prev = 1'b0;
        while (vsync !== 1'b0 && guard < FRAME_LIMIT) begin
            act = {r[7:5], g[7:5], b[7:6]};
            compare_bit("channel padding", 1'b0, |{r[4:0], g[4:0], b[5:0]});
            if (blank_n === 1'b1) begin
                if (prev !== 1'b1) begin
                    line++;
                    px = 0;
                end
                if (line < V_ACTIVE) begin
                    compare_color(px, line, expected_pixel(px, line), act);
                end
                px++;
            end else begin
                if (prev === 1'b1) begin
                    compare_count("active pixels in a line", H_ACTIVE, px);
                end
                // blanking stays dark
                compare_color(-1, -1, 8'h00, act);
            end
            prev = blank_n;
            @(negedge vga_clk);
            guard++;
        end
        if (guard >= FRAME_LIMIT) begin
            report_timeout("vsync");
        end else begin
            compare_count("active lines in a frame", V_ACTIVE, line + 1);
        end
    endtask

    task automatic test_reset_frame();
        int len;
        begin_test("reset_frame");
        repeat (15) @(posedge vga_clk);
        @(negedge vga_clk);
        compare_bit("hsync in reset", 1'b1, hsync);
        compare_bit("vsync in reset", 1'b1, vsync);
        compare_bit("blank_n in reset", 1'b0, blank_n);
        compare_bit("update_ready in reset", 1'b0, update_ready);
        compare_bit("color in reset", 1'b0, |{r, g, b});
        @(posedge vga_clk);
        rst_n <= 1'b1;
        measure_low_run(0, len);
        compare_count("hsync pulse cycles", 96, len);
        measure_low_run(1, len);
        compare_count("vsync pulse cycles", 2 * 800, len);
        scan_frame();
        end_test();
    endtask

    task automatic test_marks();
        begin_test("marks");
        send_update(0, 0, make_info(1, 0, 0, 0, 0, 0));
        send_update(0, 11, make_info(1, 0, 0, 0, 0, 0));
        send_update(0, 99, make_info(1, 0, 0, 0, 0, 0));
        send_update(1, 5, make_info(1, 0, 0, 0, 0, 0));
        send_update(0, 9, make_info(2, 0, 0, 0, 0, 0));
        send_update(0, 55, make_info(2, 0, 0, 0, 0, 0));
        send_update(1, 90, make_info(2, 0, 0, 0, 0, 0));
        send_update(1, 37, make_info(2, 0, 0, 0, 0, 0));
        scan_frame();
        end_test();
    endtask

    task automatic test_ships();
        int row;
        begin_test("ships");
        for (int k = 0; k < 4; k++) begin
            for (int v = 0; v < 2; v++) begin
                row = 2 * k + v;
                for (int bd = 0; bd < 2; bd++) begin
                    send_update(bd, row * 10 + 2, make_info(3, k, 0, v, 0, 0));
                    send_update(bd, row * 10 + 3, make_info(3, k, 1, v, 0, 0));
                end
            end
        end
        scan_frame();
        end_test();
    endtask

    task automatic test_flags();
        begin_test("flags");
        send_update(0, 20, make_info(0, 0, 0, 0, 0, 1));
        send_update(0, 21, make_info(1, 0, 0, 0, 1, 0));
        send_update(1, 66, make_info(2, 0, 0, 0, 1, 1));
        send_update(1, 88, make_info(3, 2, 0, 1, 1, 0));
        send_update(1, 87, make_info(3, 1, 1, 0, 0, 1));
        scan_frame();
        end_test();
    endtask

    task automatic test_backpressure();
        int guard;
        int idx;
        int val;
        begin_test("backpressure");
        guard = 0;
        // catch the start of an active line so the offer meets a low ready
        while (update_ready !== 1'b1 && guard < FRAME_LIMIT) begin
            @(negedge vga_clk);
            guard++;
        end
        while (update_ready !== 1'b0 && guard < FRAME_LIMIT) begin
            @(negedge vga_clk);
            guard++;
        end
        if (guard >= FRAME_LIMIT) begin
            report_timeout("active video");
        end
        send_update(1, 77, make_info(2, 0, 0, 0, 0, 0));
        compare_bit("update held off in active video", 1'b1, last_stall > 0);
        for (int i = 0; i < 24; i++) begin
            take_bits(7, idx);
            take_bits(10, val);
            send_update(i % 2, idx % 100, ppu_pkg::square_info_t'(val[9:0]));
        end
        scan_frame();
        end_test();
    endtask

    initial begin
        rst_n        <= 1'b0;
        update       <= '0;
        update_valid <= 1'b0;
        lfsr          = 32'h6812d390;
        hung          = 1'b0;
        total_errors  = 0;
        failed_tests  = 0;
        test_count    = 0;
        for (int bd = 0; bd < 2; bd++) begin
            for (int i = 0; i < 100; i++) begin
                ref_mem[bd][i] = '0;
            end
        end
        test_reset_frame();
        if (!hung) test_marks();
        if (!hung) test_ships();
        if (!hung) test_flags();
        if (!hung) test_backpressure();
        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
source/ppu_pkg.sv
source/vga_timing.sv
source/square_store.sv
source/square_locate.sv
source/sprite_fetch.sv
source/pixel_compose.sv
source/ppu_top.sv
tb/ppu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ppu_tb -f sources.f \
    && ./obj_dir/Vppu_tb | tee /dev/stderr | grep -q "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
